//--- common/shared_access_settings.svh
`ifndef SHARED_ACCESS_SETTINGS_SVH
`define SHARED_ACCESS_SETTINGS_SVH

// ******************************
// Peer side
// ******************************

// Number of peer request channels sharing the memory
`define SA_NUM_PEERS 4

// ******************************
// Memory side
// ******************************

// Word address width on the shared channel and on APB
`define SA_ADDR_W 8

// Data width of one memory word
`define SA_DATA_W 32

// Implemented words, addresses at or above this are out of range
`define SA_MEM_DEPTH 64

// Extra access cycles before pready goes high
`define SA_WAIT_STATES 2

`endif

//--- common/shared_access_pkg.sv
`include "shared_access_settings.svh"

package shared_access_pkg;

	// ******************************
	// Shared channel payloads
	// ******************************

	// One access as presented by a peer
	typedef struct packed
	{
		logic write;
		logic [`SA_ADDR_W-1:0] addr;
		logic [`SA_DATA_W-1:0] wdata;
	} sa_req_t;

	// Result handed back to the peer
	// rdata is zero for writes and for errors
	typedef struct packed
	{
		logic [`SA_DATA_W-1:0] rdata;
		logic error;
	} sa_rsp_t;

	// ******************************
	// APB bundles
	// ******************************

	// Master to slave
	typedef struct packed
	{
		logic psel;
		logic penable;
		logic pwrite;
		logic [`SA_ADDR_W-1:0] paddr;
		logic [`SA_DATA_W-1:0] pwdata;
	} sa_apb_m2s_t;

	// Slave to master
	typedef struct packed
	{
		logic [`SA_DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} sa_apb_s2m_t;

endpackage

//--- arbiter/rr_channel_arbiter.sv
`timescale 1ns/1ps

module rr_channel_arbiter
#(
	parameter type REQ_T = logic [7:0],
	parameter type RSP_T = logic [7:0],
	parameter int NUM = 2
)
(
	input logic rvx_port_03,
	input logic rvx_port_02,

	// Peer side
	input logic [NUM-1:0] req,
	input logic [NUM-1:0] lock,
	input REQ_T req_data [NUM],
	output logic [NUM-1:0] rsp_valid,
	output RSP_T rsp_data [NUM],
	output logic [NUM-1:0] owner,

	// Shared channel side
	output logic ch_valid,
	output REQ_T ch_req,
	input logic ch_ack,
	input RSP_T ch_rsp
);

	typedef enum logic [1:0]
	{
		ARB_IDLE,
		ARB_ARM,
		ARB_ISSUE,
		ARB_RESP
	} arb_state_t;

	arb_state_t state;

	// Owner status derived from the one-hot pointer
	logic owner_req;
	logic other_req;
	logic owner_lock;
	logic rotate;
	logic launch;
	logic ch_done;
	logic [NUM-1:0] owner_next;
	REQ_T owner_data;

	assign owner_req = |(owner & req);
	assign other_req = |(~owner & req);
	assign owner_lock = |(owner & lock);

	// Move on only when the owner is idle and somebody else waits
	assign rotate = (state == ARB_IDLE) && !owner_req && other_req;

	// Request goes out of ARM while the owner still holds it
	assign launch = (state == ARB_ARM) && owner_req;
	assign ch_done = ch_valid && ch_ack;

	// Rotate toward higher index, top wraps to peer 0
	assign owner_next = {owner[NUM-2:0], owner[NUM-1]};

	// ******************************
	// Channel state machine
	// ******************************

	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			state <= ARB_IDLE;
		else
		begin
			case (state)
				ARB_IDLE:
					if (owner_req)
						state <= ARB_ARM;
				ARB_ARM:
					if (owner_req)
						state <= ARB_ISSUE;
				ARB_ISSUE:
					if (ch_done)
						state <= ARB_RESP;
				ARB_RESP:
					// Locked owner goes straight back for its next access
					if (owner_lock)
						state <= ARB_ARM;
					else
						state <= ARB_IDLE;
				default:
					state <= ARB_IDLE;
			endcase
		end
	end

	// Owner pointer, peer 0 first after reset
	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			owner <= NUM'(1);
		else if (rotate)
			owner <= owner_next;
	end

	// ******************************
	// Request mux and channel
	// ******************************

	// One-hot select of the owner's request
	always_comb
	begin
		owner_data = req_data[0];
		for (int k = 1; k < NUM; k++)
			if (owner[k])
				owner_data = req_data[k];
	end

	// Valid held until the bridge acknowledges
	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			ch_valid <= 1'b0;
		else if (ch_done)
			ch_valid <= 1'b0;
		else if (launch)
			ch_valid <= 1'b1;
	end

	// Captured with valid, then frozen for the whole transfer
	always_ff @(posedge rvx_port_03)
	begin
		if (launch)
			ch_req <= owner_data;
	end

	// ******************************
	// Per-peer response registers
	// ******************************

	// Only the owner's slot takes the returned response
	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
		begin
			for (int k = 0; k < NUM; k++)
				rsp_data[k] <= '0;
		end
		else if (ch_done)
		begin
			for (int k = 0; k < NUM; k++)
				if (owner[k])
					rsp_data[k] <= ch_rsp;
		end
	end

	// One-cycle pulse on the owner's line
	assign rsp_valid = (state == ARB_RESP) ? owner : '0;

	// Pointer never loses or duplicates its token
	a_owner_onehot: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_02)
		$onehot(owner));

	// Bridge sees a stable request until it acknowledges
	a_req_stable: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_02)
		ch_valid && !ch_ack |=> ch_valid && $stable(ch_req));

endmodule

//--- verilog/apb_master_bridge.sv
`timescale 1ns/1ps

module apb_master_bridge
	import shared_access_pkg::*;
(
	input logic rvx_port_03,
	input logic rvx_port_02,

	// Request/acknowledge channel from the arbiter
	input logic ch_valid,
	input sa_req_t ch_req,
	output logic ch_ack,
	output sa_rsp_t ch_rsp,

	// APB master port
	output sa_apb_m2s_t apb_out,
	input sa_apb_s2m_t apb_in
);

	typedef enum logic [1:0]
	{
		BR_IDLE,
		BR_SETUP,
		BR_ACCESS
	} br_state_t;

	br_state_t state;
	sa_req_t xfer;
	logic start;
	logic done;

	// ch_valid is still high during the ack cycle
	// so a pending ack blocks a second start
	assign start = (state == BR_IDLE) && ch_valid && !ch_ack;

	// Completing APB cycle
	assign done = (state == BR_ACCESS) && apb_in.pready;

	// ******************************
	// APB phase sequencing
	// ******************************

	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			state <= BR_IDLE;
		else
		begin
			case (state)
				BR_IDLE:
					if (start)
						state <= BR_SETUP;
				BR_SETUP:
					state <= BR_ACCESS;
				BR_ACCESS:
					// Wait states hold us here
					if (done)
						state <= BR_IDLE;
				default:
					state <= BR_IDLE;
			endcase
		end
	end

	// Ack one cycle after the completing cycle
	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			ch_ack <= 1'b0;
		else
			ch_ack <= done;
	end

	// Request copy for the transfer and the returned response
	always_ff @(posedge rvx_port_03)
	begin
		if (start)
			xfer <= ch_req;
		if (done)
		begin
			ch_rsp.rdata <= apb_in.prdata;
			ch_rsp.error <= apb_in.pslverr;
		end
	end

	// Bus outputs straight from state and latched request
	always_comb
	begin
		apb_out.psel = (state != BR_IDLE);
		apb_out.penable = (state == BR_ACCESS);
		apb_out.pwrite = xfer.write;
		apb_out.paddr = xfer.addr;
		apb_out.pwdata = xfer.wdata;
	end

	// Access phase only inside a selected transfer that the arbiter still holds
	a_penable_with_psel: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_02)
		apb_out.penable |-> apb_out.psel && ch_valid);

endmodule

//--- verilog/apb_scratch_memory.sv
`timescale 1ns/1ps
`include "shared_access_settings.svh"

module apb_scratch_memory
	import shared_access_pkg::*;
(
	input logic rvx_port_03,
	input logic rvx_port_02,
	input sa_apb_m2s_t apb_in,
	output sa_apb_s2m_t apb_out
);

	localparam int IDX_W = $clog2(`SA_MEM_DEPTH);
	localparam int CNT_W = $clog2(`SA_WAIT_STATES + 2);
	localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`SA_WAIT_STATES);
	localparam logic [`SA_ADDR_W:0] DEPTH_LIM = (`SA_ADDR_W + 1)'(`SA_MEM_DEPTH);

	logic [`SA_DATA_W-1:0] mem [`SA_MEM_DEPTH];
	logic [CNT_W-1:0] wait_cnt;
	logic [IDX_W-1:0] idx;
	logic access;
	logic in_range;
	logic ready;

	// Access phase of a transfer
	assign access = apb_in.psel && apb_in.penable;

	// Upper bound check, extra bit keeps a full-range depth legal
	assign in_range = ({1'b0, apb_in.paddr} < DEPTH_LIM);
	assign idx = apb_in.paddr[IDX_W-1:0];

	// Ready once the wait states have been spent
	assign ready = access && (wait_cnt == WAIT_LAST);

	// ******************************
	// Wait-state counter
	// ******************************

	// Counts access cycles, restarts for each transfer
	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
			wait_cnt <= '0;
		else if (!access || ready)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	// ******************************
	// Storage
	// ******************************

	// Writes land in the completing cycle, out of range is dropped
	always_ff @(posedge rvx_port_03, negedge rvx_port_02)
	begin
		if (!rvx_port_02)
		begin
			for (int k = 0; k < `SA_MEM_DEPTH; k++)
				mem[k] <= '0;
		end
		else if (ready && apb_in.pwrite && in_range)
			mem[idx] <= apb_in.pwdata;
	end

	// Response valid only alongside pready
	always_comb
	begin
		apb_out.pready = ready;
		apb_out.pslverr = ready && !in_range;
		if (ready && in_range && !apb_in.pwrite)
			apb_out.prdata = mem[idx];
		else
			apb_out.prdata = '0;
	end

	// Setup is always followed by access to the same address
	a_setup_then_access: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_02)
		apb_in.psel && !apb_in.penable |=> access && $stable(apb_in.paddr));

endmodule

//--- verilog/shared_access_top.sv
`timescale 1ns/1ps
`include "shared_access_settings.svh"

module shared_access_top
	import shared_access_pkg::*;
(
	input logic rvx_port_03,
	input logic rvx_port_02,

	// Peer channels
	input logic [`SA_NUM_PEERS-1:0] req,
	input logic [`SA_NUM_PEERS-1:0] lock,
	input sa_req_t req_data [`SA_NUM_PEERS],
	output logic [`SA_NUM_PEERS-1:0] rsp_valid,
	output sa_rsp_t rsp_data [`SA_NUM_PEERS],
	output logic [`SA_NUM_PEERS-1:0] owner
);

	// Arbiter to bridge
	logic ch_valid;
	sa_req_t ch_req;
	logic ch_ack;
	sa_rsp_t ch_rsp;

	// APB between bridge and memory
	sa_apb_m2s_t apb_m2s;
	sa_apb_s2m_t apb_s2m;

	rr_channel_arbiter
	#(
		.REQ_T(sa_req_t),
		.RSP_T(sa_rsp_t),
		.NUM(`SA_NUM_PEERS)
	)
	i_arbiter
	(
		.rvx_port_03(rvx_port_03),
		.rvx_port_02(rvx_port_02),
		.req(req),
		.lock(lock),
		.req_data(req_data),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.owner(owner),
		.ch_valid(ch_valid),
		.ch_req(ch_req),
		.ch_ack(ch_ack),
		.ch_rsp(ch_rsp)
	);

	apb_master_bridge i_bridge
	(
		.rvx_port_03(rvx_port_03),
		.rvx_port_02(rvx_port_02),
		.ch_valid(ch_valid),
		.ch_req(ch_req),
		.ch_ack(ch_ack),
		.ch_rsp(ch_rsp),
		.apb_out(apb_m2s),
		.apb_in(apb_s2m)
	);

	apb_scratch_memory i_memory
	(
		.rvx_port_03(rvx_port_03),
		.rvx_port_02(rvx_port_02),
		.apb_in(apb_m2s),
		.apb_out(apb_s2m)
	);

endmodule

//--- bench/shared_access_tb.sv
`timescale 1ns/1ps
`include "shared_access_settings.svh"

module shared_access_tb
	import shared_access_pkg::*;
();

	localparam int NP = `SA_NUM_PEERS;
	localparam int MAX_LINES = 64;
	localparam int FIELDS = 8;
	localparam int CLK_HALF = 20;
	localparam int RSP_TIMEOUT = 200;

	logic rvx_port_03;
	logic rvx_port_02;
	logic [NP-1:0] req;
	logic [NP-1:0] lock;
	sa_req_t req_data [NP];
	logic [NP-1:0] rsp_valid;
	sa_rsp_t rsp_data [NP];
	logic [NP-1:0] owner;

	// Golden words with FIELDS entries per access line
	logic [31:0] golden [MAX_LINES*FIELDS];
	// Last response each peer should still be holding
	sa_rsp_t rsp_model [NP];

	// Per-peer queues of golden line numbers for the running group
	int line_queue [NP][MAX_LINES];
	int queue_len [NP];
	int queue_pos [NP];

	// Drive actions decided at the falling edge and applied at the rising edge
	logic [NP-1:0] rearm;
	logic [NP-1:0] drop;
	logic [NP-1:0] advance;

	// Arbitration history used to predict the next served peer
	int last_peer;
	logic last_locked;
	logic first_in_group;

	int mismatch_count;
	int timeout_count;
	int protocol_count;
	int num_lines;
	int seed;
	logic aborted;

	shared_access_top DUT
	(
		.rvx_port_03(rvx_port_03),
		.rvx_port_02(rvx_port_02),
		.req(req),
		.lock(lock),
		.req_data(req_data),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.owner(owner)
	);

	initial
	begin
		rvx_port_03 = 1'b0;
		forever #CLK_HALF rvx_port_03 = ~rvx_port_03;
	end

	// ******************************
	// Helpers
	// ******************************

	// Golden columns are group peer write addr wdata lock rdata error
	function automatic logic [31:0] golden_field(input int line, input int col);
		return golden[line*FIELDS + col];
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			mismatch_count++;
			$display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Puts the peer's current queued access on its channel
	task automatic present_access(input int p);
		int ln;
		logic [31:0] v;
		ln = line_queue[p][queue_pos[p]];
		v = golden_field(ln, 2);
		req_data[p].write <= v[0];
		v = golden_field(ln, 3);
		req_data[p].addr <= v[`SA_ADDR_W-1:0];
		req_data[p].wdata <= golden_field(ln, 4);
		v = golden_field(ln, 5);
		lock[p] <= v[0];
		req[p] <= 1'b1;
	endtask

	// Owner requesting at group start goes first and lock keeps the owner
	// Otherwise the first pending peer after the last one served
	function automatic int predict_peer();
		int p;
		if (last_locked)
			return last_peer;
		if (first_in_group && queue_pos[last_peer] < queue_len[last_peer])
			return last_peer;
		for (int step = 1; step <= NP; step++)
		begin
			p = (last_peer + step) % NP;
			if (queue_pos[p] < queue_len[p])
				return p;
		end
		return -1;
	endfunction

	task automatic take_response(input int p, output bit taken);
		int ln;
		int expect_peer;
		logic [31:0] v;
		sa_rsp_t exp_rsp;
		taken = 1'b0;
		expect_peer = predict_peer();
		if (queue_pos[p] >= queue_len[p])
		begin
			$display("peer %0d got a response with no access pending", p);
			protocol_count++;
			return;
		end
		taken = 1'b1;
		ln = line_queue[p][queue_pos[p]];
		check_value($sformatf("line %0d served peer", ln), 64'(expect_peer), 64'(p));
		exp_rsp.rdata = golden_field(ln, 6);
		v = golden_field(ln, 7);
		exp_rsp.error = v[0];
		check_value($sformatf("line %0d rdata", ln), 64'(exp_rsp.rdata),
			64'(rsp_data[p].rdata));
		check_value($sformatf("line %0d error", ln), 64'(exp_rsp.error),
			64'(rsp_data[p].error));
		rsp_model[p] = exp_rsp;
		// Other peers keep what they had
		for (int q = 0; q < NP; q++)
			if (q != p)
				check_value($sformatf("line %0d held rsp of peer %0d", ln, q),
					64'(rsp_model[q]), 64'(rsp_data[q]));
		v = golden_field(ln, 5);
		last_peer = p;
		last_locked = v[0];
		first_in_group = 1'b0;
		queue_pos[p]++;
		if (last_locked)
			advance[p] = 1'b1;
		else
			drop[p] = 1'b1;
	endtask

	// Locked peer moves straight to its next access
	// Others release for a cycle
	task automatic apply_drives();
		for (int p = 0; p < NP; p++)
		begin
			if (rearm[p])
			begin
				present_access(p);
				rearm[p] = 1'b0;
			end
			else if (advance[p] || drop[p])
			begin
				if (advance[p] && queue_pos[p] < queue_len[p])
					present_access(p);
				else
				begin
					req[p] <= 1'b0;
					lock[p] <= 1'b0;
					rearm[p] = (queue_pos[p] < queue_len[p]);
				end
				advance[p] = 1'b0;
				drop[p] = 1'b0;
			end
		end
	endtask

	// ******************************
	// One group of golden lines
	// ******************************

	task automatic run_group(input int first, input int count);
		int p;
		int outstanding;
		int idle_cycles;
		bit taken;
		logic [31:0] v;
		for (int k = 0; k < NP; k++)
		begin
			queue_len[k] = 0;
			queue_pos[k] = 0;
		end
		for (int i = first; i < first + count; i++)
		begin
			v = golden_field(i, 1);
			p = v;
			line_queue[p][queue_len[p]] = i;
			queue_len[p]++;
		end
		first_in_group = 1'b1;
		outstanding = count;
		idle_cycles = 0;
		// Nobody requested since the last response so the pointer stays put
		@(negedge rvx_port_03);
		check_value($sformatf("group %0h owner at start", golden_field(first, 0)),
			64'(1) << last_peer, 64'(owner));
		// All peers of the group raise together
		@(posedge rvx_port_03);
		for (int k = 0; k < NP; k++)
			if (queue_len[k] > 0)
				present_access(k);
		while (outstanding > 0 && !aborted)
		begin
			@(negedge rvx_port_03);
			if (!$onehot(owner))
			begin
				$display("owner pointer is not one-hot: %b", owner);
				protocol_count++;
			end
			if (rsp_valid != '0)
			begin
				idle_cycles = 0;
				if (!$onehot0(rsp_valid))
				begin
					$display("more than one rsp_valid high at once: %b", rsp_valid);
					protocol_count++;
				end
				for (int k = 0; k < NP; k++)
					if (rsp_valid[k])
					begin
						take_response(k, taken);
						if (taken)
							outstanding--;
					end
			end
			else
			begin
				idle_cycles++;
				if (idle_cycles >= RSP_TIMEOUT)
				begin
					$display("timeout: group %0h got no response for %0d cycles",
						golden_field(first, 0), RSP_TIMEOUT);
					timeout_count++;
					aborted = 1'b1;
				end
			end
			@(posedge rvx_port_03);
			apply_drives();
		end
	endtask

	// ******************************
	// Main sequence
	// ******************************

	initial
	begin
		int start;
		int count;
		int gap;
		rvx_port_02 <= 1'b0;
		req <= '0;
		lock <= '0;
		for (int k = 0; k < NP; k++)
		begin
			req_data[k] <= '0;
			rsp_model[k] = '0;
		end
		rearm = '0;
		drop = '0;
		advance = '0;
		mismatch_count = 0;
		timeout_count = 0;
		protocol_count = 0;
		aborted = 1'b0;
		seed = 32'haa9b;
		last_peer = 0;
		last_locked = 1'b0;
		first_in_group = 1'b0;
		// Unread entries keep their inverted index and mark the end of the line list
		for (int i = 0; i < MAX_LINES*FIELDS; i++)
			golden[i] = ~32'(i);
		$readmemh("bench/shared_access_golden.txt", golden);
		num_lines = 0;
		while (num_lines < MAX_LINES
			&& golden_field(num_lines, 0) != ~32'(num_lines*FIELDS))
			num_lines++;
		if (num_lines == 0)
		begin
			$display("golden file holds no accesses");
			protocol_count++;
		end
		repeat (10) @(posedge rvx_port_03);
		rvx_port_02 <= 1'b1;
		start = 0;
		while (start < num_lines && !aborted)
		begin
			count = 1;
			while (start + count < num_lines
				&& golden_field(start + count, 0) == golden_field(start, 0))
				count++;
			// Random idle time between groups
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(posedge rvx_port_03);
			run_group(start, count);
			start += count;
		end
		$display("errors: %0d mismatch, %0d timeout, %0d protocol",
			mismatch_count, timeout_count, protocol_count);
		if (mismatch_count + timeout_count + protocol_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- shared_access.f
+incdir+common
common/shared_access_pkg.sv
arbiter/rr_channel_arbiter.sv
verilog/apb_master_bridge.sv
verilog/apb_scratch_memory.sv
verilog/shared_access_top.sv
bench/shared_access_tb.sv

//--- Makefile
# Verilator build and run for the shared access subsystem

VERILATOR ?= verilator
TOP ?= shared_access_tb
FILELIST ?= shared_access.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
GOLDEN ?= bench/shared_access_golden.txt
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -q '^test passed$$' $(LOG) || { echo "simulation reported failure, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/shared_access_golden.txt
// group peer write addr wdata lock exp_rdata exp_error
// All hex, lines of one group are presented on their peers' channels together
0 1 1 05 11111111 0 00000000 0
1 2 0 05 00000000 0 11111111 0
2 0 1 10 a0a0a0a0 0 00000000 0
2 1 1 11 b1b1b1b1 0 00000000 0
2 3 1 13 d3d3d3d3 0 00000000 0
3 0 0 11 00000000 0 b1b1b1b1 0
3 1 0 13 00000000 0 d3d3d3d3 0
3 2 0 10 00000000 0 a0a0a0a0 0
3 3 0 05 00000000 0 11111111 0
4 1 1 21 0000beef 0 00000000 0
4 2 1 20 cafe0001 1 00000000 0
4 2 0 20 00000000 0 cafe0001 0
4 3 0 21 00000000 0 0000beef 0
5 0 1 22 12345678 1 00000000 0
5 0 1 23 87654321 1 00000000 0
5 0 0 22 00000000 0 12345678 0
5 1 0 23 00000000 0 87654321 0
6 1 1 40 deadbeef 0 00000000 1
6 2 1 ff 5555aaaa 0 00000000 1
7 3 0 00 00000000 0 00000000 0
7 0 0 3f 00000000 0 00000000 0
7 3 0 40 00000000 0 00000000 1
8 0 1 30 00000030 0 00000000 0
8 0 0 30 00000000 0 00000030 0
8 1 1 31 00000031 0 00000000 0
8 2 0 31 00000000 0 00000031 0
8 3 1 3f 3f3f3f3f 1 00000000 0
8 3 0 3f 00000000 0 3f3f3f3f 0
9 1 0 10 00000000 0 a0a0a0a0 0
9 2 0 13 00000000 0 d3d3d3d3 0
9 2 1 10 0f0f0f0f 0 00000000 0
9 3 0 10 00000000 0 a0a0a0a0 0
a 0 0 10 00000000 0 0f0f0f0f 0
a 1 1 3e 77777777 1 00000000 0
a 1 0 3e 00000000 0 77777777 0
